// File: project.f
+incdir+rtl
+incdir+verification
rtl/lc4_pkg.sv
rtl/lc4_decoder.sv
rtl/lc4_regfile_dual.sv
rtl/lc4_alu.sv
rtl/lc4_bypass.sv
rtl/lc4_issue_ctrl.sv
rtl/lc4_back_end.sv
rtl/lc4_dual_pipe.sv
verification/lc4_dual_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the LC4 dual pipe testbench with Verilator, run it, then check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f project.f \
    --top-module lc4_dual_pipe_tb -o lc4_dual_pipe_sim \
    && ./obj_dir/lc4_dual_pipe_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "simulation did not build or run"; exit 1; }

cat sim.log

# a run that ended without any verdict also counts as a failure
grep -q "Test completed successfully" sim.log || exit 1
grep -q "Test failed" sim.log && exit 1 || exit 0

// File: verification/lc4_tb_programs.svh
`ifndef LC4_TB_PROGRAMS_SVH
`define LC4_TB_PROGRAMS_SVH

// one entry per test: program words from pc 0, program length, data words
// laid over the random fill from DATA_BASE on, and the expected store count
localparam int NUM_TESTS = 3;
localparam int MAX_LEN = 10;
localparam int DATA_WORDS = 4;
localparam logic [15:0] DATA_BASE = 16'h0010;

localparam int PROG_LEN [NUM_TESTS] = '{8, 10, 9};
localparam int STORE_CNT [NUM_TESTS] = '{0, 2, 2};

localparam logic [15:0] PROGS [NUM_TESTS][MAX_LEN] = '{
    '{
        // const r1,5 / const r2,-3 / add r3,r1,r2 / sub r4,r3,r1
        16'h9205, 16'h95fd, 16'h1642, 16'h18d1,
        // and r5,r4,r2 / addi r6,r5,-1 / addi r7,r7,7 / add r1,r6,r7
        16'h5b02, 16'h1d7f, 16'h1fe7, 16'h1387,
        16'h0000, 16'h0000
    },
    '{
        // const r1,16 / ldr r2,r1,0 / add r3,r2,r2 / ldr r4,r1,1
        16'h9210, 16'h6440, 16'h1682, 16'h6841,
        // const r5,1 / add r6,r4,r5 / str r6,r1,2 / str r3,r1,-1
        16'h9a01, 16'h1d05, 16'h7c42, 16'h767f,
        // ldr r7,r1,2 / add r7,r7,r7
        16'h6e42, 16'h1fc7
    },
    '{
        // const r1,1 / const r1,2 / add r2,r1,r1 / nop
        16'h9201, 16'h9202, 16'h1441, 16'h0000,
        // add r3,r1,r2 / str r3,r0,5 / ldr r4,r0,5 / str r4,r0,6
        16'h1642, 16'h7605, 16'h6805, 16'h7806,
        // add r5,r4,r4
        16'h1b04, 16'h0000
    }
};

localparam logic [15:0] DATA_INIT [NUM_TESTS][DATA_WORDS] = '{
    '{16'h0000, 16'h0000, 16'h0000, 16'h0000},
    '{16'h1234, 16'h0ff0, 16'h5a5a, 16'h0001},
    '{16'h7fff, 16'h8000, 16'h00aa, 16'h0055}
};

`endif

// File: verification/lc4_dual_pipe_tb.sv
`include "lc4_cfg.svh"

module lc4_dual_pipe_tb;
    import lc4_pkg::*;

    `include "lc4_tb_programs.svh"

    localparam int CLK_PERIOD = 40;
    localparam int MEM_WORDS = 2 ** `LC4_WORD_W;

    logic      gwe = 1'b0;
    logic      rst_n = 1'b0;
    word_t     cur_pc;
    word_t     insn_a;
    word_t     insn_b;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    retire_t   retire_a;
    retire_t   retire_b;

    word_t imem [MEM_WORDS];
    word_t dmem [MEM_WORDS];
    word_t model_mem [MEM_WORDS];

    // what the in-order model expects, oldest first
    retire_t     exp_ret [$];
    dmem_req_t   exp_st [$];
    logic [31:0] lcg_state = 32'h6b917594;
    int          cur_test;
    int          retired;
    int          stores;
    int          checks;
    int          errors;

    lc4_dual_pipe lc4_dual_pipe_i (
        .gwe(gwe), .i_rst_n(rst_n), .o_cur_pc(cur_pc),
        .i_insn_a(insn_a), .i_insn_b(insn_b),
        .o_dmem(dmem_req), .i_dmem_rdata(dmem_rdata),
        .o_retire_a(retire_a), .o_retire_b(retire_b)
    );

    always #(CLK_PERIOD / 2) gwe = ~gwe;

    // both memories answer in the same cycle
    assign insn_a = imem[cur_pc];
    assign insn_b = imem[cur_pc + 16'd1];
    assign dmem_rdata = dmem[dmem_req.addr];

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int total_insns();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TESTS; t++)
            n += PROG_LEN[t];
        return n;
    endfunction

    // both retiring slots went through the memory stage in the same cycle
    function automatic logic both_use_dmem(input retire_t a, input retire_t b);
        logic a_mem;
        logic b_mem;
        a_mem = a.insn[15:12] == 4'h6 || a.insn[15:12] == 4'h7;
        b_mem = b.insn[15:12] == 4'h6 || b.insn[15:12] == 4'h7;
        return a.valid && b.valid && a_mem && b_mem;
    endfunction

    task automatic compare_field(input string what, input word_t got, input word_t want);
        checks++;
        assert (got === want) else begin
            $display("Error: time %0t, test %0d, %s got %h, expected %h",
                     $time, cur_test, what, got, want);
            errors++;
        end
    endtask

    task automatic prepare_memories(input int t);
        for (int a = 0; a < MEM_WORDS; a++) begin
            lcg_state = lcg_next(lcg_state);
            // random word mixed with its own address
            dmem[a] = lcg_state[31:16] ^ 16'(a);
            imem[a] = `LC4_NOP_INSN;
        end
        for (int i = 0; i < PROG_LEN[t]; i++)
            imem[i] = PROGS[t][i];
        for (int i = 0; i < DATA_WORDS; i++)
            dmem[DATA_BASE + 16'(i)] = DATA_INIT[t][i];
        model_mem = dmem;
        exp_ret.delete();
        exp_st.delete();
    endtask

    // executes the program one instruction at a time from pc 0
    task automatic run_model(input int t);
        word_t     regs [`LC4_REG_CNT];
        word_t     insn;
        word_t     rs_v;
        word_t     rt_v;
        word_t     addr;
        word_t     val;
        retire_t   e;
        dmem_req_t s;
        foreach (regs[i])
            regs[i] = '0;
        for (int pc = 0; pc < PROG_LEN[t]; pc++) begin
            insn = PROGS[t][pc];
            rs_v = regs[insn[8:6]];
            rt_v = regs[insn[2:0]];
            addr = rs_v + {{10{insn[5]}}, insn[5:0]};
            val = '0;
            e = '0;
            e.valid = 1'b1;
            e.pc = 16'(pc);
            e.insn = insn;
            e.wsel = insn[11:9];
            case (insn[15:12])
                4'h1: begin
                    if (insn[5]) begin
                        e.we = 1'b1;
                        val = rs_v + {{11{insn[4]}}, insn[4:0]};
                    end else if (insn[5:3] == 3'b000) begin
                        e.we = 1'b1;
                        val = rs_v + rt_v;
                    end else if (insn[5:3] == 3'b010) begin
                        e.we = 1'b1;
                        val = rs_v - rt_v;
                    end
                end
                4'h5: begin
                    e.we = (insn[5:3] == 3'b000);
                    val = rs_v & rt_v;
                end
                4'h6: begin
                    e.we = 1'b1;
                    val = model_mem[addr];
                end
                4'h7: begin
                    // stored register comes from bits 11:9
                    s.we = 1'b1;
                    s.addr = addr;
                    s.wdata = regs[insn[11:9]];
                    model_mem[addr] = s.wdata;
                    exp_st.push_back(s);
                end
                4'h9: begin
                    e.we = 1'b1;
                    val = {{7{insn[8]}}, insn[8:0]};
                end
                default: ;
            endcase
            if (e.we) begin
                regs[insn[11:9]] = val;
                e.wdata = val;
            end
            exp_ret.push_back(e);
        end
    endtask

    task automatic inspect_retire(input retire_t r, input string slot);
        retire_t e;
        if (r.valid && retired < PROG_LEN[cur_test]) begin
            e = exp_ret.pop_front();
            compare_field({slot, " pc"}, r.pc, e.pc);
            compare_field({slot, " insn"}, r.insn, e.insn);
            compare_field({slot, " we"}, 16'(r.we), 16'(e.we));
            if (e.we) begin
                compare_field({slot, " wsel"}, 16'(r.wsel), 16'(e.wsel));
                compare_field({slot, " wdata"}, r.wdata, e.wdata);
            end
            retired++;
        end
    endtask

    task automatic match_store;
        dmem_req_t e;
        stores++;
        dmem[dmem_req.addr] = dmem_req.wdata;
        assert (exp_st.size() > 0) else begin
            $display("test %0d: store to %h at time %0t, but the program has no store left",
                     cur_test, dmem_req.addr, $time);
            errors++;
        end
        if (exp_st.size() > 0) begin
            e = exp_st.pop_front();
            compare_field("store addr", dmem_req.addr, e.addr);
            compare_field("store data", dmem_req.wdata, e.wdata);
        end
    endtask

    initial begin
        int err_before;
        int cycles;
        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_test = t;
            err_before = errors;
            retired = 0;
            stores = 0;
            // reset held for two cycles while the memories are loaded
            @(posedge gwe);
            rst_n <= 1'b0;
            @(negedge gwe);
            prepare_memories(t);
            run_model(t);
            @(posedge gwe);
            @(posedge gwe);
            rst_n <= 1'b1;
            @(negedge gwe);
            compare_field("pc after reset", cur_pc, `LC4_RESET_PC);
            compare_field("retire valid after reset",
                          16'({retire_a.valid, retire_b.valid}), 16'd0);
            compare_field("store after reset", 16'(dmem_req.we), 16'd0);
            cycles = 0;
            while (retired < PROG_LEN[t]) begin
                @(negedge gwe);
                cycles++;
                // the first pair reaches writeback four cycles after reset
                if (cycles < 4)
                    compare_field("retire or store before writeback",
                                  16'({retire_a.valid, retire_b.valid, dmem_req.we}), 16'd0);
                if (cycles == 4)
                    compare_field("first slot A retire", 16'(retire_a.valid), 16'd1);
                compare_field("data accesses in one cycle",
                              16'(both_use_dmem(retire_a, retire_b)), 16'd0);
                if (dmem_req.we)
                    match_store();
                inspect_retire(retire_a, "slot A");
                inspect_retire(retire_b, "slot B");
            end
            compare_field("store count", 16'(stores), 16'(STORE_CNT[t]));
            $display("test %0d: %0d retired, %0d stores, %0d errors",
                     t, retired, stores, errors - err_before);
        end
        $display("%0d tests run, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    // eight cycles per instruction plus the reset of each test
    initial begin
        int limit;
        limit = total_insns() * 8 + NUM_TESTS * 4;
        #(limit * CLK_PERIOD);
        $display("watchdog: the tests did not finish within %0d cycles", limit);
        $display("Test failed");
        $finish;
    end

endmodule

// File: rtl/lc4_dual_pipe.sv
module lc4_dual_pipe (
    input  logic               gwe,
    input  logic               i_rst_n,
    output lc4_pkg::word_t     o_cur_pc,
    input  lc4_pkg::word_t     i_insn_a,
    input  lc4_pkg::word_t     i_insn_b,
    output lc4_pkg::dmem_req_t o_dmem,
    input  lc4_pkg::word_t     i_dmem_rdata,
    output lc4_pkg::retire_t   o_retire_a,
    output lc4_pkg::retire_t   o_retire_b
);
    import lc4_pkg::*;

    slot_t dec_a, dec_b, iss_a, iss_b, ex_a, ex_b;
    word_t rf_rs_a, rf_rt_a, rf_rs_b, rf_rt_b;

    lc4_issue_ctrl issue_i (
        .gwe(gwe), .i_rst_n(i_rst_n),
        .i_insn_a(i_insn_a), .i_insn_b(i_insn_b),
        .i_ex_a(ex_a), .i_ex_b(ex_b),
        .o_cur_pc(o_cur_pc),
        .o_dec_a(dec_a), .o_dec_b(dec_b),
        .o_iss_a(iss_a), .o_iss_b(iss_b)
    );

    // read in decode, write from the retire records
    lc4_regfile_dual regfile_i (
        .gwe(gwe), .i_rst_n(i_rst_n),
        .i_rs_a(dec_a.dec.rs), .i_rt_a(dec_a.dec.rt),
        .i_rs_b(dec_b.dec.rs), .i_rt_b(dec_b.dec.rt),
        .o_rs_data_a(rf_rs_a), .o_rt_data_a(rf_rt_a),
        .o_rs_data_b(rf_rs_b), .o_rt_data_b(rf_rt_b),
        .i_wr_a(o_retire_a), .i_wr_b(o_retire_b)
    );

    lc4_back_end back_end_i (
        .gwe(gwe), .i_rst_n(i_rst_n),
        .i_iss_a(iss_a), .i_iss_b(iss_b),
        .i_rf_rs_a(rf_rs_a), .i_rf_rt_a(rf_rt_a),
        .i_rf_rs_b(rf_rs_b), .i_rf_rt_b(rf_rt_b),
        .i_dmem_rdata(i_dmem_rdata),
        .o_ex_a(ex_a), .o_ex_b(ex_b),
        .o_dmem(o_dmem),
        .o_retire_a(o_retire_a), .o_retire_b(o_retire_b)
    );

endmodule

// File: rtl/lc4_back_end.sv
module lc4_back_end (
    input  logic              gwe,
    input  logic              i_rst_n,
    input  lc4_pkg::slot_t    i_iss_a,
    input  lc4_pkg::slot_t    i_iss_b,
    input  lc4_pkg::word_t    i_rf_rs_a,
    input  lc4_pkg::word_t    i_rf_rt_a,
    input  lc4_pkg::word_t    i_rf_rs_b,
    input  lc4_pkg::word_t    i_rf_rt_b,
    input  lc4_pkg::word_t    i_dmem_rdata,
    output lc4_pkg::slot_t    o_ex_a,
    output lc4_pkg::slot_t    o_ex_b,
    output lc4_pkg::dmem_req_t o_dmem,
    output lc4_pkg::retire_t  o_retire_a,
    output lc4_pkg::retire_t  o_retire_b
);
    import lc4_pkg::*;

    slot_t ex_a, ex_b, mem_a, mem_b, wb_a, wb_b;
    word_t ex_rs_a, ex_rt_a, ex_rs_b, ex_rt_b;
    word_t rs_a, rt_a, rs_b, rt_b;
    word_t alu_a, alu_b;
    word_t mem_res_a, mem_res_b, mem_st_a, mem_st_b;
    word_t st_a, st_b;
    word_t wb_res_a, wb_res_b, wb_ld;
    logic  mem_a_uses_port;

    lc4_bypass bypass_i (
        .i_ex_a(ex_a), .i_ex_b(ex_b), .i_mem_a(mem_a), .i_mem_b(mem_b),
        .i_mem_res_a(mem_res_a), .i_mem_res_b(mem_res_b),
        .i_mem_st_a(mem_st_a), .i_mem_st_b(mem_st_b),
        .i_wb_a(o_retire_a), .i_wb_b(o_retire_b),
        .i_rf_rs_a(ex_rs_a), .i_rf_rt_a(ex_rt_a),
        .i_rf_rs_b(ex_rs_b), .i_rf_rt_b(ex_rt_b),
        .o_rs_a(rs_a), .o_rt_a(rt_a), .o_rs_b(rs_b), .o_rt_b(rt_b),
        .o_st_a(st_a), .o_st_b(st_b)
    );

    lc4_alu alu_a_i (.i_dec(ex_a.dec), .i_rs_val(rs_a), .i_rt_val(rt_a), .o_result(alu_a));
    lc4_alu alu_b_i (.i_dec(ex_b.dec), .i_rs_val(rs_b), .i_rt_val(rt_b), .o_result(alu_b));

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            ex_a <= bubble_slot(STALL_RESET);
            ex_b <= bubble_slot(STALL_RESET);
            mem_a <= bubble_slot(STALL_RESET);
            mem_b <= bubble_slot(STALL_RESET);
            wb_a <= bubble_slot(STALL_RESET);
            wb_b <= bubble_slot(STALL_RESET);
        end else begin
            ex_a <= i_iss_a;
            ex_b <= i_iss_b;
            mem_a <= ex_a;
            mem_b <= ex_b;
            wb_a <= mem_a;
            wb_b <= mem_b;
        end
    end

    always_ff @(posedge gwe) begin
        ex_rs_a <= i_rf_rs_a;
        ex_rt_a <= i_rf_rt_a;
        ex_rs_b <= i_rf_rs_b;
        ex_rt_b <= i_rf_rt_b;
        mem_res_a <= alu_a;
        mem_res_b <= alu_b;
        mem_st_a <= rt_a;
        mem_st_b <= rt_b;
        wb_res_a <= mem_res_a;
        wb_res_b <= mem_res_b;
        // only one slot reads memory per cycle, so one register is enough
        wb_ld <= i_dmem_rdata;
    end

    // switching keeps two memory ops out of the same stage
    assign mem_a_uses_port = mem_a.valid && (mem_a.dec.is_load || mem_a.dec.is_store);

    always_comb begin
        o_dmem.we = (mem_a.valid && mem_a.dec.is_store) || (mem_b.valid && mem_b.dec.is_store);
        o_dmem.addr = mem_a_uses_port ? mem_res_a : mem_res_b;
        o_dmem.wdata = mem_a_uses_port ? st_a : st_b;
    end

    function automatic retire_t make_retire(input slot_t s, input word_t res, input word_t ld);
        retire_t r;
        r.valid = s.valid;
        r.pc = s.pc;
        r.insn = s.insn;
        r.we = s.valid && s.dec.rd_we;
        r.wsel = s.dec.rd;
        r.wdata = s.dec.is_load ? ld : res;
        return r;
    endfunction

    assign o_retire_a = make_retire(wb_a, wb_res_a, wb_ld);
    assign o_retire_b = make_retire(wb_b, wb_res_b, wb_ld);
    assign o_ex_a = ex_a;
    assign o_ex_b = ex_b;

endmodule

// File: rtl/lc4_issue_ctrl.sv
`include "lc4_cfg.svh"

module lc4_issue_ctrl (
    input  logic           gwe,
    input  logic           i_rst_n,
    input  lc4_pkg::word_t i_insn_a,
    input  lc4_pkg::word_t i_insn_b,
    input  lc4_pkg::slot_t i_ex_a,
    input  lc4_pkg::slot_t i_ex_b,
    output lc4_pkg::word_t o_cur_pc,
    output lc4_pkg::slot_t o_dec_a,
    output lc4_pkg::slot_t o_dec_b,
    output lc4_pkg::slot_t o_iss_a,
    output lc4_pkg::slot_t o_iss_b
);
    import lc4_pkg::*;

    word_t    pc;
    slot_t    dec_a;
    slot_t    dec_b;
    decoded_t fet_dec_a;
    decoded_t fet_dec_b;
    slot_t    fet_a;
    slot_t    fet_b;
    logic     b_needs_a;
    logic     mem_conflict;
    logic     ltu_a;
    logic     ltu_b;
    logic     stall;
    logic     do_switch;

    lc4_decoder dec_a_i (.i_insn(i_insn_a), .o_dec(fet_dec_a));
    lc4_decoder dec_b_i (.i_insn(i_insn_b), .o_dec(fet_dec_b));

    always_comb begin
        fet_a = '{valid: 1'b1, pc: pc, insn: i_insn_a, dec: fet_dec_a, stall: STALL_NONE};
        fet_b = '{valid: 1'b1, pc: pc + 1'b1, insn: i_insn_b, dec: fet_dec_b,
                  stall: STALL_NONE};
    end

    // consumer needs a load still in execute; store data is exempt
    // since it can be picked up later in the memory stage
    function automatic logic load_use(input slot_t c, input slot_t p);
        logic hit;
        hit = c.dec.rs_re && c.dec.rs == p.dec.rd;
        hit = hit || (c.dec.rt_re && !c.dec.is_store && c.dec.rt == p.dec.rd);
        return c.valid && p.valid && p.dec.is_load && hit;
    endfunction

    assign b_needs_a = dec_a.valid && dec_b.valid && dec_a.dec.rd_we
                     && ((dec_b.dec.rs_re && dec_b.dec.rs == dec_a.dec.rd)
                      || (dec_b.dec.rt_re && dec_b.dec.rt == dec_a.dec.rd));
    assign mem_conflict = dec_a.valid && dec_b.valid
                        && (dec_a.dec.is_load || dec_a.dec.is_store)
                        && (dec_b.dec.is_load || dec_b.dec.is_store);
    assign ltu_a = load_use(dec_a, i_ex_a) || load_use(dec_a, i_ex_b);
    assign ltu_b = load_use(dec_b, i_ex_a) || load_use(dec_b, i_ex_b);

    // a stalls everything, b alone only gets split off
    assign stall = ltu_a;
    assign do_switch = !stall && (b_needs_a || mem_conflict || ltu_b);

    always_comb begin
        if (stall) begin
            o_iss_a = bubble_slot(STALL_LOAD);
            o_iss_b = bubble_slot(STALL_LOAD);
        end else begin
            o_iss_a = dec_a;
            o_iss_b = do_switch ? bubble_slot(STALL_PIPE) : dec_b;
        end
    end

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            pc <= `LC4_RESET_PC;
            dec_a <= bubble_slot(STALL_RESET);
            dec_b <= bubble_slot(STALL_RESET);
        end else if (do_switch) begin
            // old b moves up, the fetch at pc fills b
            pc <= pc + 16'd1;
            dec_a <= dec_b;
            dec_b <= fet_a;
        end else if (!stall) begin
            pc <= pc + 16'd2;
            dec_a <= fet_a;
            dec_b <= fet_b;
        end
    end

    assign o_cur_pc = pc;
    assign o_dec_a = dec_a;
    assign o_dec_b = dec_b;

endmodule

// File: rtl/lc4_bypass.sv
module lc4_bypass (
    input  lc4_pkg::slot_t   i_ex_a,
    input  lc4_pkg::slot_t   i_ex_b,
    input  lc4_pkg::slot_t   i_mem_a,
    input  lc4_pkg::slot_t   i_mem_b,
    input  lc4_pkg::word_t   i_mem_res_a,
    input  lc4_pkg::word_t   i_mem_res_b,
    input  lc4_pkg::word_t   i_mem_st_a,
    input  lc4_pkg::word_t   i_mem_st_b,
    input  lc4_pkg::retire_t i_wb_a,
    input  lc4_pkg::retire_t i_wb_b,
    input  lc4_pkg::word_t   i_rf_rs_a,
    input  lc4_pkg::word_t   i_rf_rt_a,
    input  lc4_pkg::word_t   i_rf_rs_b,
    input  lc4_pkg::word_t   i_rf_rt_b,
    output lc4_pkg::word_t   o_rs_a,
    output lc4_pkg::word_t   o_rt_a,
    output lc4_pkg::word_t   o_rs_b,
    output lc4_pkg::word_t   o_rt_b,
    output lc4_pkg::word_t   o_st_a,
    output lc4_pkg::word_t   o_st_b
);
    import lc4_pkg::*;

    // load data is not ready in memory, the stall logic covers it
    function automatic logic mem_hit(input slot_t p, input sel_t sel);
        return p.valid && p.dec.rd_we && !p.dec.is_load && p.dec.rd == sel;
    endfunction

    function automatic logic wb_hit(input retire_t p, input sel_t sel);
        return p.valid && p.we && p.wsel == sel;
    endfunction

    // youngest producer first: mem b, mem a, wb b, wb a
    function automatic word_t mx_wx(input sel_t sel, input word_t rf);
        word_t val;
        val = rf;
        if (wb_hit(i_wb_a, sel))
            val = i_wb_a.wdata;
        if (wb_hit(i_wb_b, sel))
            val = i_wb_b.wdata;
        if (mem_hit(i_mem_a, sel))
            val = i_mem_res_a;
        if (mem_hit(i_mem_b, sel))
            val = i_mem_res_b;
        return val;
    endfunction

    always_comb begin
        o_rs_a = mx_wx(i_ex_a.dec.rs, i_rf_rs_a);
        o_rt_a = mx_wx(i_ex_a.dec.rt, i_rf_rt_a);
        o_rs_b = mx_wx(i_ex_b.dec.rs, i_rf_rs_b);
        o_rt_b = mx_wx(i_ex_b.dec.rt, i_rf_rt_b);

        // store data in the memory stage
        o_st_a = i_mem_st_a;
        if (wb_hit(i_wb_b, i_mem_a.dec.rt))
            o_st_a = i_wb_b.wdata;
        else if (wb_hit(i_wb_a, i_mem_a.dec.rt))
            o_st_a = i_wb_a.wdata;

        o_st_b = i_mem_st_b;
        if (wb_hit(i_wb_b, i_mem_b.dec.rt))
            o_st_b = i_wb_b.wdata;
        else if (wb_hit(i_wb_a, i_mem_b.dec.rt))
            o_st_b = i_wb_a.wdata;
        else if (mem_hit(i_mem_a, i_mem_b.dec.rt))
            o_st_b = i_mem_res_a;
    end

endmodule

// File: rtl/lc4_alu.sv
module lc4_alu (
    input  lc4_pkg::decoded_t i_dec,
    input  lc4_pkg::word_t    i_rs_val,
    input  lc4_pkg::word_t    i_rt_val,
    output lc4_pkg::word_t    o_result
);
    import lc4_pkg::*;

    always_comb begin
        case (i_dec.op)
            OP_ADD:   o_result = i_rs_val + i_rt_val;
            OP_SUB:   o_result = i_rs_val - i_rt_val;
            OP_AND:   o_result = i_rs_val & i_rt_val;
            // memory ops reuse the adder for the address
            OP_ADDI,
            OP_LDR,
            OP_STR:   o_result = i_rs_val + i_dec.imm;
            OP_CONST: o_result = i_dec.imm;
            default:  o_result = '0;
        endcase
    end

endmodule

// File: rtl/lc4_regfile_dual.sv
`include "lc4_cfg.svh"

module lc4_regfile_dual (
    input  logic             gwe,
    input  logic             i_rst_n,
    input  lc4_pkg::sel_t    i_rs_a,
    input  lc4_pkg::sel_t    i_rt_a,
    input  lc4_pkg::sel_t    i_rs_b,
    input  lc4_pkg::sel_t    i_rt_b,
    output lc4_pkg::word_t   o_rs_data_a,
    output lc4_pkg::word_t   o_rt_data_a,
    output lc4_pkg::word_t   o_rs_data_b,
    output lc4_pkg::word_t   o_rt_data_b,
    input  lc4_pkg::retire_t i_wr_a,
    input  lc4_pkg::retire_t i_wr_b
);
    import lc4_pkg::*;

    word_t regs [`LC4_REG_CNT];

    // same-cycle writes are visible to reads, b is younger so it wins
    function automatic word_t rd_port(input sel_t sel);
        word_t val;
        val = regs[sel];
        if (i_wr_a.valid && i_wr_a.we && i_wr_a.wsel == sel)
            val = i_wr_a.wdata;
        if (i_wr_b.valid && i_wr_b.we && i_wr_b.wsel == sel)
            val = i_wr_b.wdata;
        return val;
    endfunction

    always_comb begin
        o_rs_data_a = rd_port(i_rs_a);
        o_rt_data_a = rd_port(i_rt_a);
        o_rs_data_b = rd_port(i_rs_b);
        o_rt_data_b = rd_port(i_rt_b);
    end

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `LC4_REG_CNT; i++)
                regs[i] <= '0;
        end else begin
            if (i_wr_a.valid && i_wr_a.we)
                regs[i_wr_a.wsel] <= i_wr_a.wdata;
            if (i_wr_b.valid && i_wr_b.we)
                regs[i_wr_b.wsel] <= i_wr_b.wdata;
        end
    end

endmodule

// File: rtl/lc4_decoder.sv
`include "lc4_cfg.svh"

module lc4_decoder (
    input  lc4_pkg::word_t    i_insn,
    output lc4_pkg::decoded_t o_dec
);
    import lc4_pkg::*;

    always_comb begin
        o_dec = '0;
        o_dec.op = OP_NOP;
        o_dec.rd = i_insn[`LC4_RD_HI:`LC4_RD_LO];
        o_dec.rs = i_insn[`LC4_RS_HI:`LC4_RS_LO];
        o_dec.rt = i_insn[`LC4_RT_HI:`LC4_RT_LO];
        case (i_insn[`LC4_OP_HI:`LC4_OP_LO])
            4'b0000: o_dec.op = OP_NOP;
            4'b0001: begin
                // bit 5 picks the imm5 form
                if (i_insn[5]) begin
                    o_dec.op = OP_ADDI;
                    o_dec.imm = {{(`LC4_WORD_W-5){i_insn[4]}}, i_insn[4:0]};
                end else if (i_insn[5:3] == 3'b000) begin
                    o_dec.op = OP_ADD;
                end else if (i_insn[5:3] == 3'b010) begin
                    o_dec.op = OP_SUB;
                end else begin
                    o_dec.op = OP_ILLEGAL;
                end
            end
            4'b0101: o_dec.op = (i_insn[5:3] == 3'b000) ? OP_AND : OP_ILLEGAL;
            4'b0110: begin
                o_dec.op = OP_LDR;
                o_dec.imm = {{(`LC4_WORD_W-6){i_insn[5]}}, i_insn[5:0]};
            end
            4'b0111: begin
                o_dec.op = OP_STR;
                // store data register sits in the rd field
                o_dec.rt = i_insn[`LC4_RD_HI:`LC4_RD_LO];
                o_dec.imm = {{(`LC4_WORD_W-6){i_insn[5]}}, i_insn[5:0]};
            end
            4'b1001: begin
                o_dec.op = OP_CONST;
                o_dec.imm = {{(`LC4_WORD_W-9){i_insn[8]}}, i_insn[8:0]};
            end
            default: o_dec.op = OP_ILLEGAL;
        endcase

        o_dec.rs_re = o_dec.op inside {OP_ADD, OP_SUB, OP_AND, OP_ADDI, OP_LDR, OP_STR};
        o_dec.rt_re = o_dec.op inside {OP_ADD, OP_SUB, OP_AND, OP_STR};
        o_dec.rd_we = o_dec.op inside {OP_ADD, OP_SUB, OP_AND, OP_ADDI, OP_CONST, OP_LDR};
        o_dec.is_load = (o_dec.op == OP_LDR);
        o_dec.is_store = (o_dec.op == OP_STR);
    end

endmodule

// File: rtl/lc4_pkg.sv
`include "lc4_cfg.svh"

package lc4_pkg;

    typedef logic [`LC4_WORD_W-1:0] word_t;
    typedef logic [`LC4_SEL_W-1:0] sel_t;

    // supported operations, anything else runs as a nop
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_ADDI,
        OP_CONST,
        OP_LDR,
        OP_STR,
        OP_ILLEGAL
    } opcode_e;

    // why a slot is empty in a given stage
    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_PIPE  = 2'd1,
        STALL_RESET = 2'd2,
        STALL_LOAD  = 2'd3
    } stall_e;

    typedef struct packed {
        opcode_e op;
        sel_t    rs;
        sel_t    rt;
        sel_t    rd;
        logic    rs_re;
        logic    rt_re;
        logic    rd_we;
        logic    is_load;
        logic    is_store;
        word_t   imm;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        decoded_t dec;
        stall_e   stall;
    } slot_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t insn;
        logic  we;
        sel_t  wsel;
        word_t wdata;
    } retire_t;

    // empty slot tagged with the reason it is empty
    function automatic slot_t bubble_slot(input stall_e why);
        slot_t s;
        s = '0;
        s.insn = `LC4_NOP_INSN;
        s.stall = why;
        return s;
    endfunction

endpackage

// File: rtl/lc4_cfg.svh
`ifndef LC4_CFG_SVH
`define LC4_CFG_SVH

// datapath and instruction width
`define LC4_WORD_W 16

// register file size and select width
`define LC4_REG_CNT 8
`define LC4_SEL_W $clog2(`LC4_REG_CNT)

// instruction field positions
`define LC4_OP_HI 15
`define LC4_OP_LO 12
`define LC4_RD_HI 11
`define LC4_RD_LO 9
`define LC4_RS_HI 8
`define LC4_RS_LO 6
`define LC4_RT_HI 2
`define LC4_RT_LO 0

`define LC4_RESET_PC 16'h0000
`define LC4_NOP_INSN 16'h0000

`endif
